/* src.f */
hdl/uart_pkg.sv
hdl/uart_cfg_if.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
testbench/tb_clk_gen.sv
testbench/tb_uart.sv

/* testbench/tb_uart.sv */
////////////////////////////////////////
// Directed tests of the UART over its register bus and serial lines.
// Inputs change 2 ns after the rising edge; tasks end on that phase.
////////////////////////////////////////

`timescale 1ns/1ns

module tb_uart;
  import uart_pkg::*;

  localparam int WAIT_LIMIT = 4000;
  localparam int RX_DIV     = 16;
  localparam logic [BUS_W-1:0] TX_DONE_BITS = (1 << ST_TX_EMPTY) | (1 << ST_TX_IDLE);
  localparam logic [BUS_W-1:0] IDLE_STATUS  = TX_DONE_BITS | (1 << ST_RX_EMPTY);

  logic              clk;
  logic              rst_n;
  logic              reg_we;
  logic              reg_re;
  logic [ADDR_W-1:0] reg_addr;
  logic [BUS_W-1:0]  reg_wdata;
  logic [BUS_W-1:0]  reg_rdata;
  logic              tx;
  logic              rx;
  int                checks;
  int                errors;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  uart_top u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .tx_o        (tx),
    .rx_i        (rx)
  );

  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check(input string name, input logic [BUS_W-1:0] expected,
                       input logic [BUS_W-1:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [BUS_W-1:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    next_cycles(1);
    reg_we    = 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [BUS_W-1:0] data);
    reg_re   = 1'b1;
    reg_addr = addr;
    next_cycles(1);
    reg_re   = 1'b0;
    data     = reg_rdata; // Registered at the edge just passed.
  endtask

  task automatic send_frame(input logic [DATA_W-1:0] data, input logic stop_bit,
                            input int div);
    rx = 1'b0;
    next_cycles(div);
    for (int i = 0; i < DATA_W; i++) begin
      rx = data[i];
      next_cycles(div);
    end
    rx = stop_bit;
    next_cycles(div);
    rx = 1'b1;
  endtask

  // Samples tx_o every cycle; bits are taken at mid-symbol.
  task automatic recv_frame(input int div, output logic [DATA_W-1:0] data,
                            output logic stop_bit, output int start_w);
    int   waited;
    int   sym;
    logic low_run;
    waited   = 0;
    data     = '0;
    stop_bit = 1'b0;
    start_w  = 0;
    low_run  = 1'b1;
    while (tx !== 1'b0 && waited < WAIT_LIMIT) begin
      next_cycles(1);
      waited++;
    end
    if (tx !== 1'b0) begin
      errors++;
      $display("Timed out waiting for a start bit on tx_o.");
      return;
    end
    for (int i = 0; i < 10 * div; i++) begin
      sym = i / div;
      if (low_run && tx === 1'b0) start_w++;
      else low_run = 1'b0;
      if (i % div == div / 2) begin
        if (sym >= 1 && sym <= DATA_W) data[sym-1] = tx;
        else if (sym == DATA_W + 1) stop_bit = tx;
      end
      next_cycles(1);
    end
  endtask

  task automatic wait_status(input int bit_pos, input logic value, input string what);
    logic [BUS_W-1:0] status;
    int               waited;
    waited = 0;
    bus_read(ADDR_STATUS, status);
    while (status[bit_pos] !== value && waited < WAIT_LIMIT) begin
      bus_read(ADDR_STATUS, status);
      waited++;
    end
    if (status[bit_pos] !== value) begin
      errors++;
      $display("Timed out waiting for %s in STATUS.", what);
    end
  endtask

  task automatic test_reset();
    logic [BUS_W-1:0] rdata;
    int               high_cnt;
    high_cnt = 0;
    check("reset read data", '0, reg_rdata);
    for (int i = 0; i < 50; i++) begin
      if (tx === 1'b1) high_cnt++;
      next_cycles(1);
    end
    check("reset tx_o high cycles", 50, high_cnt);
    bus_read(ADDR_STATUS, rdata);
    check("reset status", IDLE_STATUS, rdata);
    bus_read(ADDR_DIV, rdata);
    check("reset divisor", DIV_RESET, rdata);
    bus_read(ADDR_CTRL, rdata);
    check("reset control", '0, rdata);
  endtask

  task automatic test_tx_framing();
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] got;
    logic              stop;
    int                width;
    b = 8'($urandom) | 8'h01; // Bit 0 high ends the start bit cleanly.
    bus_write(ADDR_DIV, 16'd8);
    bus_write(ADDR_CTRL, 16'h0001);
    bus_write(ADDR_TXDATA, {8'h00, b});
    recv_frame(8, got, stop, width);
    check("tx framing data", b, got);
    check("tx framing stop bit", 1, stop);
    check("tx start bit width within one cycle of 8", 1, width >= 7 && width <= 9);
  endtask

  task automatic test_tx_queue();
    logic [DATA_W-1:0] sent [5];
    logic [DATA_W-1:0] got;
    logic [BUS_W-1:0]  rdata;
    logic              stop;
    int                width;
    bus_write(ADDR_CTRL, 16'h0000); // Hold frames back while the divisor changes.
    for (int i = 0; i < 5; i++) begin
      sent[i] = 8'($urandom);
      bus_write(ADDR_TXDATA, {8'h00, sent[i]});
    end
    bus_write(ADDR_DIV, 16'd5);
    bus_write(ADDR_CTRL, 16'h0001);
    for (int i = 0; i < 5; i++) begin
      recv_frame(5, got, stop, width);
      check("tx queue byte", sent[i], got);
      check("tx queue stop bit", 1, stop);
    end
    bus_read(ADDR_STATUS, rdata);
    check("tx queue drained status", TX_DONE_BITS, rdata & TX_DONE_BITS);
  endtask

  task automatic test_rx_path();
    logic [DATA_W-1:0] b;
    logic [BUS_W-1:0]  rdata;
    bus_write(ADDR_DIV, 16'(RX_DIV));
    bus_write(ADDR_CTRL, 16'h0003);
    bus_read(ADDR_CTRL, rdata);
    check("control readback", 16'h0003, rdata);
    for (int i = 0; i < 3; i++) begin
      b = 8'($urandom);
      send_frame(b, 1'b1, RX_DIV);
      wait_status(ST_RX_EMPTY, 1'b0, "a received byte");
      bus_read(ADDR_RXDATA, rdata);
      check("rx byte", {8'h00, b}, rdata);
    end
    bus_read(ADDR_RXDATA, rdata);
    check("rx read when empty", '0, rdata);
  endtask

  task automatic test_rx_errors();
    logic [BUS_W-1:0] rdata;
    send_frame(8'($urandom), 1'b0, RX_DIV);
    wait_status(ST_FRAME_ERR, 1'b1, "the frame error flag");
    bus_read(ADDR_STATUS, rdata);
    check("frame error leaves rx empty", 1, rdata[ST_RX_EMPTY]);
    rx = 1'b0;
    next_cycles(RX_DIV / 4); // Well short of the mid-symbol check.
    rx = 1'b1;
    next_cycles(RX_DIV * 12);
    bus_read(ADDR_STATUS, rdata);
    check("glitch leaves rx empty", 1, rdata[ST_RX_EMPTY]);
    bus_write(ADDR_STATUS, 16'h0000);
    bus_read(ADDR_STATUS, rdata);
    check("frame error cleared", 0, rdata[ST_FRAME_ERR]);
  endtask

  task automatic test_overrun();
    logic [DATA_W-1:0] sent [RX_FIFO_DEPTH + 1];
    logic [BUS_W-1:0]  rdata;
    for (int i = 0; i <= RX_FIFO_DEPTH; i++) begin
      sent[i] = 8'($urandom);
      send_frame(sent[i], 1'b1, RX_DIV);
    end
    wait_status(ST_OVERRUN, 1'b1, "the overrun flag");
    for (int i = 0; i < RX_FIFO_DEPTH; i++) begin
      bus_read(ADDR_RXDATA, rdata);
      check("overrun kept byte", {8'h00, sent[i]}, rdata);
    end
    bus_read(ADDR_RXDATA, rdata);
    check("overrun dropped byte", '0, rdata);
  endtask

  initial begin
    int waited;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    rx        = 1'b1;
    checks    = 0;
    errors    = 0;
    waited    = 0;
    void'($urandom(32'h9625));
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Reset was never released.");
    end
    next_cycles(1);
    test_reset();
    test_tx_framing();
    test_tx_queue();
    test_rx_path();
    test_rx_errors();
    test_overrun();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* testbench/tb_clk_gen.sv */
////////////////////////////////////////
// 20 ns clock; reset low for 3 cycles.
////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #2 rst_no = 1'b1; // Released off the edge, like the other inputs.
  end

endmodule

/* hdl/uart_top.sv */
////////////////////////////////////////
// UART top with a register bus and 8N1 serial lines.
// No flow control, parity or interrupts.
////////////////////////////////////////

`timescale 1ns/1ns

module uart_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       reg_we_i,
  input  logic                       reg_re_i,
  input  logic [uart_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [uart_pkg::BUS_W-1:0]  reg_wdata_i,
  output logic [uart_pkg::BUS_W-1:0]  reg_rdata_o,
  output logic                       tx_o,
  input  logic                       rx_i
);
  import uart_pkg::*;

  logic              tx_push;
  logic              tx_pop;
  logic [DATA_W-1:0] tx_wdata;
  logic [DATA_W-1:0] tx_rdata;
  logic              tx_full;
  logic              tx_empty;
  logic              rx_push;
  logic              rx_pop;
  logic [DATA_W-1:0] rx_wdata;
  logic [DATA_W-1:0] rx_rdata;
  logic              rx_full;
  logic              rx_empty;

  uart_cfg_if u_cfg ();

  uart_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_e'(reg_addr_i)),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .cfg         (u_cfg),
    .tx_push_o   (tx_push),
    .tx_data_o   (tx_wdata),
    .tx_full_i   (tx_full),
    .tx_empty_i  (tx_empty),
    .rx_pop_o    (rx_pop),
    .rx_data_i   (rx_rdata),
    .rx_empty_i  (rx_empty),
    .rx_full_i   (rx_full),
    .rx_push_i   (rx_push)
  );

  uart_fifo #(.DEPTH(TX_FIFO_DEPTH)) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tx_push),
    .wdata_i (tx_wdata),
    .pop_i   (tx_pop),
    .rdata_o (tx_rdata),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  uart_fifo #(.DEPTH(RX_FIFO_DEPTH)) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rx_push),
    .wdata_i (rx_wdata),
    .pop_i   (rx_pop),
    .rdata_o (rx_rdata),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  uart_tx u_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg          (u_cfg),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_rdata),
    .fifo_pop_o   (tx_pop),
    .tx_o         (tx_o)
  );

  uart_rx u_rx (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg         (u_cfg),
    .rx_i        (rx_i),
    .fifo_push_o (rx_push),
    .fifo_data_o (rx_wdata)
  );

endmodule

/* hdl/uart_regs.sv */
////////////////////////////////////////
// Register block for control, divisor, FIFO access and status.
// Read data is registered and holds until the next read strobe.
////////////////////////////////////////

`timescale 1ns/1ns

module uart_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        reg_we_i,
  input  logic                        reg_re_i,
  input  uart_pkg::reg_addr_e         reg_addr_i,
  input  logic [uart_pkg::BUS_W-1:0]  reg_wdata_i,
  output logic [uart_pkg::BUS_W-1:0]  reg_rdata_o,

  uart_cfg_if.regs                    cfg,

  output logic                        tx_push_o,
  output logic [uart_pkg::DATA_W-1:0] tx_data_o,
  input  logic                        tx_full_i,
  input  logic                        tx_empty_i,

  output logic                        rx_pop_o,
  input  logic [uart_pkg::DATA_W-1:0] rx_data_i,
  input  logic                        rx_empty_i,
  input  logic                        rx_full_i,
  input  logic                        rx_push_i
);
  import uart_pkg::*;

  logic             tx_en_q;
  logic             rx_en_q;
  logic [DIV_W-1:0] div_q;
  logic             frame_err_q;
  logic             overrun_q;
  logic             wr_ctrl;
  logic             wr_div;
  logic             wr_status;
  logic [BUS_W-1:0] status;
  logic [BUS_W-1:0] rdata_d;

  assign wr_ctrl   = reg_we_i && (reg_addr_i == ADDR_CTRL);
  assign wr_div    = reg_we_i && (reg_addr_i == ADDR_DIV);
  assign wr_status = reg_we_i && (reg_addr_i == ADDR_STATUS);

  assign tx_push_o = reg_we_i && (reg_addr_i == ADDR_TXDATA) && !tx_full_i;
  assign tx_data_o = reg_wdata_i[DATA_W-1:0];
  assign rx_pop_o  = reg_re_i && (reg_addr_i == ADDR_RXDATA) && !rx_empty_i;

  assign cfg.tx_en        = tx_en_q;
  assign cfg.rx_en        = rx_en_q;
  assign cfg.clks_per_sym = div_q;

  always_comb begin
    status               = '0;
    status[ST_TX_FULL]   = tx_full_i;
    status[ST_TX_EMPTY]  = tx_empty_i;
    status[ST_TX_IDLE]   = cfg.tx_idle;
    status[ST_RX_EMPTY]  = rx_empty_i;
    status[ST_FRAME_ERR] = frame_err_q;
    status[ST_OVERRUN]   = overrun_q;
  end

  always_comb begin
    case (reg_addr_i)
      ADDR_CTRL:   rdata_d = BUS_W'({rx_en_q, tx_en_q});
      ADDR_DIV:    rdata_d = BUS_W'(div_q);
      ADDR_RXDATA: rdata_d = rx_empty_i ? '0 : BUS_W'(rx_data_i);
      ADDR_STATUS: rdata_d = status;
      default:     rdata_d = '0; // TXDATA is write only.
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tx_en_q     <= 1'b0;
      rx_en_q     <= 1'b0;
      div_q       <= DIV_RESET;
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
      reg_rdata_o <= '0;
    end else begin
      if (wr_ctrl) begin
        tx_en_q <= reg_wdata_i[0];
        rx_en_q <= reg_wdata_i[1];
      end
      if (wr_div) begin
        div_q <= reg_wdata_i[DIV_W-1:0];
      end
      // A new event in the same cycle as a clear wins.
      if (cfg.frame_err) begin
        frame_err_q <= 1'b1;
      end else if (wr_status) begin
        frame_err_q <= 1'b0;
      end
      if (rx_push_i && rx_full_i) begin
        overrun_q <= 1'b1;
      end else if (wr_status) begin
        overrun_q <= 1'b0;
      end
      if (reg_re_i) begin
        reg_rdata_o <= rdata_d;
      end
    end
  end

endmodule

/* hdl/uart_rx.sv */
////////////////////////////////////////
// 8N1 receiver with start-bit check at half a symbol.
// Bytes with a low stop bit are dropped.
////////////////////////////////////////

`timescale 1ns/1ns

module uart_rx (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  uart_cfg_if.phy                     cfg,
  input  logic                        rx_i,
  output logic                        fifo_push_o,
  output logic [uart_pkg::DATA_W-1:0] fifo_data_o
);
  import uart_pkg::*;

  rx_state_e            state_q;
  logic [1:0]           sync_q;
  logic                 prev_q;
  logic                 rx_s;
  logic [DIV_W-1:0]     cnt_q;
  logic [DIV_W-1:0]     half_sym;
  logic [DIV_W-1:0]     target;
  logic [BIT_IDX_W-1:0] bit_q;
  logic [DATA_W-1:0]    data_q;
  logic                 fall;
  logic                 sample;
  logic                 stop_now;

  assign rx_s     = sync_q[1];
  assign fall     = prev_q && !rx_s;
  assign half_sym = cfg.clks_per_sym >> 1;
  assign target   = (state_q == RX_START) ? half_sym - 1'b1 : cfg.clks_per_sym - 1'b1;
  assign sample   = (cnt_q == target);
  assign stop_now = (state_q == RX_STOP) && sample;

  assign fifo_push_o   = stop_now && rx_s;
  assign cfg.frame_err = stop_now && !rx_s;
  assign fifo_data_o   = data_q;

  // Two-flop synchronizer plus one stage for edge detection.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
      prev_q <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      prev_q <= rx_s;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && sample) begin
      data_q <= {rx_s, data_q[DATA_W-1:1]}; // LSB arrives first.
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          if (cfg.rx_en && fall) begin
            state_q <= RX_START;
            cnt_q   <= '0;
          end
        end
        RX_START: begin
          if (sample) begin
            cnt_q <= '0;
            bit_q <= '0;
            // A line that is high again was only a glitch.
            state_q <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (sample) begin
            cnt_q <= '0;
            if (bit_q == BIT_IDX_W'(DATA_W - 1)) begin
              state_q <= RX_STOP;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (sample) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/uart_tx.sv */
////////////////////////////////////////
// 8N1 serializer fed from the transmit FIFO.
// Divisors below 4 are not supported.
////////////////////////////////////////

`timescale 1ns/1ns

module uart_tx (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  uart_cfg_if.phy                     cfg,
  input  logic                        fifo_empty_i,
  input  logic [uart_pkg::DATA_W-1:0] fifo_data_i,
  output logic                        fifo_pop_o,
  output logic                        tx_o
);
  import uart_pkg::*;

  tx_state_e            state_q;
  logic [DIV_W-1:0]     cnt_q;
  logic [BIT_IDX_W-1:0] bit_q;
  logic [DATA_W-1:0]    shift_q;
  logic                 start;
  logic                 sym_end;

  assign start       = (state_q == TX_IDLE) && cfg.tx_en && !fifo_empty_i;
  assign sym_end     = (cnt_q == cfg.clks_per_sym - 1'b1);
  assign fifo_pop_o  = start;
  assign cfg.tx_idle = (state_q == TX_IDLE);

  // The low bit of shift_q is always the data bit on the line.
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= fifo_data_i;
    end else if (state_q == TX_DATA && sym_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= TX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_o    <= 1'b1;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (start) begin
            state_q <= TX_START;
            cnt_q   <= '0;
            tx_o    <= 1'b0; // Start bit.
          end
        end
        TX_START: begin
          if (sym_end) begin
            state_q <= TX_DATA;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_o    <= shift_q[0];
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        TX_DATA: begin
          if (sym_end) begin
            cnt_q <= '0;
            if (bit_q == BIT_IDX_W'(DATA_W - 1)) begin
              state_q <= TX_STOP;
              tx_o    <= 1'b1;
            end else begin
              bit_q <= bit_q + 1'b1;
              tx_o  <= shift_q[1]; // Takes the next bit before the shift.
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (sym_end) begin
            state_q <= TX_IDLE; // One idle cycle before the next frame.
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/uart_fifo.sv */
////////////////////////////////////////
// Byte FIFO with show-ahead read data.
// Push when full and pop when empty are ignored.
////////////////////////////////////////

`timescale 1ns/1ns

module uart_fifo #(
  parameter int DEPTH = uart_pkg::TX_FIFO_DEPTH
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        push_i,
  input  logic [uart_pkg::DATA_W-1:0] wdata_i,
  input  logic                        pop_i,
  output logic [uart_pkg::DATA_W-1:0] rdata_o,
  output logic                        full_o,
  output logic                        empty_o
);
  import uart_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push_ok;
  logic              pop_ok;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;
  assign rdata_o = mem_q[rd_ptr_q]; // Shows the head entry while not empty.

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_ok)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Both or neither leave the level alone.
      endcase
    end
  end

endmodule

/* hdl/uart_cfg_if.sv */
////////////////////////////////////////
// Configuration out to the serial logic, status back.
// frame_err is a single-cycle pulse.
////////////////////////////////////////

`timescale 1ns/1ns

interface uart_cfg_if;
  import uart_pkg::*;

  logic [DIV_W-1:0] clks_per_sym; // Clock cycles per serial symbol.
  logic             tx_en;
  logic             rx_en;
  logic             tx_idle;
  logic             frame_err;

  modport regs (
    output clks_per_sym, tx_en, rx_en,
    input  tx_idle, frame_err
  );

  modport phy (
    input  clks_per_sym, tx_en, rx_en,
    output tx_idle, frame_err
  );

endinterface

/* hdl/uart_pkg.sv */
////////////////////////////////////////
// Shared widths, depths and register map of the UART.
// FIFO depths need not be powers of two.
////////////////////////////////////////

package uart_pkg;

  localparam int DATA_W    = 8;
  localparam int BUS_W     = 16;
  localparam int ADDR_W    = 3;
  localparam int DIV_W     = 16;
  localparam int BIT_IDX_W = $clog2(DATA_W);

  localparam int TX_FIFO_DEPTH = 8;
  localparam int RX_FIFO_DEPTH = 4; // Small so that overrun is quick to reach.

  localparam logic [DIV_W-1:0] DIV_RESET = DIV_W'(16);

  typedef enum logic [ADDR_W-1:0] {
    ADDR_CTRL   = ADDR_W'(0),
    ADDR_DIV    = ADDR_W'(1),
    ADDR_TXDATA = ADDR_W'(2),
    ADDR_RXDATA = ADDR_W'(3),
    ADDR_STATUS = ADDR_W'(4)
  } reg_addr_e;

  localparam int ST_TX_FULL   = 0;
  localparam int ST_TX_EMPTY  = 1;
  localparam int ST_TX_IDLE   = 2;
  localparam int ST_RX_EMPTY  = 3;
  localparam int ST_FRAME_ERR = 4; // Sticky.
  localparam int ST_OVERRUN   = 5; // Sticky.

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage
